// File: uart_mmio.f
+incdir+.
uart_mmio_pkg.sv
mmio_decode.sv
tx_queue.sv
uart_serializer.sv
uart_mmio_top.sv
tb_uart_mmio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART MMIO testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tb_uart_mmio \
    -f uart_mmio.f

./obj_dir/Vtb_uart_mmio | tee sim.log

if grep -qF '** PASS **' sim.log; then
    echo "simulation passed, see sim.log"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// File: tb_uart_mmio.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_cfg.svh"

module tb_uart_mmio;
    import uart_mmio_pkg::*;

    localparam int FRAME_CYCLES  = 10 * `UART_CLKS_PER_BIT;
    localparam int FRAME_NS      = FRAME_CYCLES * 20;
    localparam int TOTAL_BYTES   = 10 + 240 + 12;   // order test, drain to 250, wrap.
    localparam int BUS_MARGIN_NS = 100000;
    localparam int TIMEOUT_NS    = 2 * TOTAL_BYTES * FRAME_NS + BUS_MARGIN_NS;

    logic        clk;
    logic        rst_n;
    mmio_req_t   bus_req;
    logic [31:0] rdata;
    logic        uart_tx;

    // reference copy of the buffer and pointers.
    logic [31:0] model_mem [0:`UART_BUF_WORDS-1];
    logic [7:0]  model_head;
    logic [7:0]  model_tail;

    logic [7:0]  rx_bytes [$];  // bytes from the receiver, not yet compared.
    int          rx_pushed;
    int          rx_popped;
    logic [7:0]  exp_idx;       // byte index of the next expected byte.
    int          bytes_left;
    int          frames_seen;
    int          frame_errors;
    int          pass_count;
    int          fail_count;
    string       cur_test;
    integer      seed;

    uart_mmio_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .rdata   (rdata),
        .uart_tx (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // lane idx modulo 4 of word idx divided by 4, lane 0 first.
    function automatic logic [7:0] expected_byte(input logic [7:0] idx);
        logic [31:0] word;
        word = model_mem[idx[7:2]];
        case (idx[1:0])
            2'd0:    return word[7:0];
            2'd1:    return word[15:8];
            2'd2:    return word[23:16];
            default: return word[31:24];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, fail_count - fails_before);
        end
    endtask

    task automatic drive_req(input logic start, input logic write,
                             input logic [31:0] addr, input logic [31:0] wdata);
        mmio_req_t req;
        req.start = start;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        bus_req <= req;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        drive_req(1'b1, 1'b1, addr, data);
        @(posedge clk);
        drive_req(1'b0, 1'b0, addr, 32'h0);    // the write lands at this edge.
    endtask

    // rdata is registered, so it is taken one cycle after the address.
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        drive_req(1'b1, 1'b0, addr, 32'h0);
        @(posedge clk);
        drive_req(1'b0, 1'b0, ~addr, 32'h0);   // move the address away before sampling.
        @(negedge clk);
        data = rdata;
    endtask

    task automatic fill_buffer();
        logic [31:0] data;
        logic [5:0]  w;
        for (int i = 0; i < `UART_BUF_WORDS; i++) begin
            w    = i[5:0];
            data = $random(seed);
            bus_write({24'h0, w, 2'b00}, data);
            model_mem[w] = data;
        end
    endtask

    task automatic set_tail(input logic [7:0] new_tail);
        exp_idx    = model_head;
        bytes_left = int'(8'(new_tail - model_head));
        model_tail = new_tail;
        bus_write(`UART_TAIL_OFFSET, {24'h0, new_tail});
    endtask

    // two quiet frames after the last byte, so a stray byte would show up.
    task automatic wait_drain();
        wait (bytes_left == 0);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        model_head = model_tail;
    endtask

    // serial receiver, samples each bit near its middle.
    initial begin : receiver
        logic [7:0] rx_byte;
        forever begin
            @(negedge uart_tx);
            if (rst_n) begin
                repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
                if (uart_tx !== 1'b0) begin
                    $display("frame %0d has a start bit that is not low", frames_seen);
                    frame_errors++;
                    fail_count++;
                end
                repeat (8) begin
                    repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                    rx_byte = {uart_tx, rx_byte[7:1]};  // lsb arrives first.
                end
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    $display("frame %0d has a stop bit that is not high", frames_seen);
                    frame_errors++;
                    fail_count++;
                end
                frames_seen++;
                rx_bytes.push_back(rx_byte);
                rx_pushed++;
            end
        end
    end

    initial begin : compare_bytes
        logic [7:0] got;
        forever begin
            wait (rx_pushed != rx_popped);
            got = rx_bytes.pop_front();
            rx_popped++;
            if (bytes_left == 0) begin
                $display("byte %h arrived while no transmission was pending", got);
                fail_count++;
            end else begin
                check_value($sformatf("%s byte %0d", cur_test, exp_idx),
                            {24'h0, expected_byte(exp_idx)}, {24'h0, got});
                exp_idx    = exp_idx + 8'd1;
                bytes_left = bytes_left - 1;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("simulation timed out after %0d ns, %0d bytes never arrived",
                 TIMEOUT_NS, bytes_left);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main_sequence
        logic [31:0] got;
        logic [31:0] data;
        logic [5:0]  w;
        logic        line_low;
        int          fails_before;
        seed       = 32'h619d;
        rst_n      = 1'b0;
        bus_req    = '0;
        model_head = 8'd0;
        model_tail = 8'd0;
        exp_idx    = 8'd0;
        bytes_left = 0;
        line_low   = 1'b0;

        // reset state.
        cur_test     = "reset_state";
        fails_before = fail_count;
        repeat (5) begin
            @(negedge clk);
            if (uart_tx !== 1'b1) line_low = 1'b1;
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (uart_tx !== 1'b1) line_low = 1'b1;
        end
        check_value("reset_state uart_tx low seen", 32'd0, {31'd0, line_low});
        bus_read(`UART_HEAD_OFFSET, got);
        check_value("reset_state head", 32'd0, got);
        bus_read(`UART_TAIL_OFFSET, got);
        check_value("reset_state tail", 32'd0, got);
        report_test(cur_test, fails_before);

        // buffer read-back, then a head write that must be ignored.
        cur_test     = "buffer_readback";
        fails_before = fail_count;
        fill_buffer();
        repeat (24) begin
            data = $random(seed);
            w    = data[5:0];
            data = $random(seed);
            bus_write({24'h0, w, 2'b00}, data);
            model_mem[w] = data;
        end
        for (int i = 0; i < `UART_BUF_WORDS; i++) begin
            w = i[5:0];
            bus_read({24'h0, w, 2'b00}, got);
            check_value($sformatf("buffer_readback word %0d", i), model_mem[w], got);
        end
        data = $random(seed);
        bus_write(`UART_HEAD_OFFSET, data);
        bus_read(`UART_HEAD_OFFSET, got);
        check_value("buffer_readback head after write", 32'(model_head), got);
        report_test(cur_test, fails_before);

        // transmission order, ten bytes from three words.
        cur_test     = "tx_order";
        fails_before = fail_count;
        for (int i = 0; i < 3; i++) begin
            w    = i[5:0];
            data = $random(seed);
            bus_write({24'h0, w, 2'b00}, data);
            model_mem[w] = data;
        end
        set_tail(8'd10);
        wait_drain();
        check_value("tx_order frames received", 32'd10, frames_seen);
        report_test(cur_test, fails_before);

        $display("test frame_format: %0d frames, %0d framing errors",
                 frames_seen, frame_errors);

        cur_test     = "head_tracking";
        fails_before = fail_count;
        bus_read(`UART_HEAD_OFFSET, got);
        check_value("head_tracking head", 32'(model_tail), got);
        report_test(cur_test, fails_before);

        // pointer wrap, drain to 250 then send across the 255 to 0 boundary.
        cur_test     = "pointer_wrap";
        fails_before = fail_count;
        set_tail(8'd250);
        wait_drain();
        fill_buffer();
        set_tail(8'd6);
        wait_drain();
        bus_read(`UART_HEAD_OFFSET, got);
        check_value("pointer_wrap head", 32'd6, got);
        check_value("pointer_wrap frames received", 32'(TOTAL_BYTES), frames_seen);
        report_test(cur_test, fails_before);

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_mmio_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire uart_mmio_pkg::mmio_req_t bus_req,
    output logic [31:0]                   rdata,
    output logic                          uart_tx
);

    uart_mmio_pkg::mmio_sel_t dec;      // decoded bus command.
    logic                     tx_ready; // line driver is idle.
    logic                     tx_start; // one-cycle handover strobe.
    logic [7:0]               tx_byte;

    // address decode.
    mmio_decode u_decode (
        .req (bus_req),
        .dec (dec)
    );

    // buffer, pointers and fetch machine.
    tx_queue u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .rdata    (rdata),
        .tx_ready (tx_ready),
        .tx_start (tx_start),
        .tx_byte  (tx_byte)
    );

    // 8N1 line driver.
    // its busy time is the only thing that holds the queue back.
    uart_serializer u_serializer (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .uart_tx  (uart_tx)
    );

endmodule

`default_nettype wire

// File: uart_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_cfg.svh"

module uart_serializer (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tx_start,
    input  wire  [7:0] tx_byte,
    output logic       tx_ready,
    output logic       uart_tx
);
    import uart_mmio_pkg::*;

    localparam int CNT_W = (`UART_CLKS_PER_BIT > 1) ? $clog2(`UART_CLKS_PER_BIT) : 1;

    ser_state_e       state;
    logic [CNT_W-1:0] bit_cnt;  // cycles spent in the current bit.
    logic [2:0]       bit_idx;  // data bit being sent.
    logic [7:0]       shift_q;
    logic             bit_end;

    assign bit_end  = (bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
    assign tx_ready = (state == SER_IDLE);

    // bit period counter, free running while a frame is on the line.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (state == SER_IDLE || bit_end) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // frame sequencing.
    // the line is registered so it changes exactly at bit boundaries.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SER_IDLE;
            uart_tx <= 1'b1;        // idle line is mark.
            bit_idx <= '0;
            shift_q <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    uart_tx <= 1'b1;
                    if (tx_start) begin
                        shift_q <= tx_byte;
                        uart_tx <= 1'b0;    // start bit.
                        state   <= SER_START;
                    end
                end
                SER_START: begin
                    if (bit_end) begin
                        uart_tx <= shift_q[0];  // lsb first.
                        shift_q <= {1'b0, shift_q[7:1]};
                        bit_idx <= '0;
                        state   <= SER_DATA;
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            uart_tx <= 1'b1;    // stop bit.
                            state   <= SER_STOP;
                        end else begin
                            uart_tx <= shift_q[0];
                            shift_q <= {1'b0, shift_q[7:1]};
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                SER_STOP: begin
                    if (bit_end) begin
                        state <= SER_IDLE;  // ready again once the stop bit is done.
                    end
                end
                default: begin
                    state   <= SER_IDLE;
                    uart_tx <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tx_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_cfg.svh"

module tx_queue (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_mmio_pkg::mmio_sel_t dec,
    output logic [31:0]               rdata,
    input  wire                       tx_ready,
    output logic                      tx_start,
    output logic [7:0]                tx_byte
);
    import uart_mmio_pkg::*;

    localparam int IDX_W = $clog2(`UART_BUF_WORDS);

    logic [31:0]            buf_mem [0:`UART_BUF_WORDS-1];
    logic [`UART_PTR_W-1:0] head;
    logic [`UART_PTR_W-1:0] tail;
    logic [IDX_W-1:0]       head_word;  // word holding the byte at the head.
    logic [1:0]             head_lane;  // byte lane within that word.
    logic [31:0]            word_q;     // word fetched for the byte in progress.
    tx_state_e              state;
    logic                   fetch_word;
    logic                   issue_byte;

    assign head_word = head[`UART_PTR_W-1:2];
    assign head_lane = head[1:0];

    // the queue is not empty and nothing is staged yet.
    assign fetch_word = (state == TXQ_IDLE) && (tail != head);

    // a word is staged and the line driver is idle.
    assign issue_byte = (state == TXQ_WAIT_READY) && tx_ready;

    // buffer writes from the bus.
    always_ff @(posedge clk) begin
        if (dec.wr && dec.sel == SEL_BUFFER) begin
            buf_mem[dec.word_index] <= dec.wdata;
        end
    end

    // tail pointer, written by software only. head writes are dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (dec.wr && dec.sel == SEL_TAIL) begin
            tail <= dec.wdata[`UART_PTR_W-1:0];
        end
    end

    // registered read port.
    // it follows the address every cycle, start or no start.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            case (dec.sel)
                SEL_HEAD: rdata <= 32'(head);   // pointers read back zero-extended.
                SEL_TAIL: rdata <= 32'(tail);
                default:  rdata <= buf_mem[dec.word_index];
            endcase
        end
    end

    // fetch machine.
    // one byte is handed over per idle period of the line driver, and the
    // next word is fetched while that byte is still being shifted out.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TXQ_IDLE;
            head     <= '0;
            tx_start <= 1'b0;
        end else begin
            case (state)
                TXQ_IDLE: begin
                    tx_start <= 1'b0;   // the strobe lasts a single cycle.
                    if (fetch_word) begin
                        state <= TXQ_WAIT_READY;
                    end
                end
                TXQ_WAIT_READY: begin
                    if (issue_byte) begin
                        tx_start <= 1'b1;
                        head     <= head + 1'b1;
                        state    <= TXQ_IDLE;
                    end
                end
                default: begin
                    state    <= TXQ_IDLE;
                    tx_start <= 1'b0;
                end
            endcase
        end
    end

    // staged word and outgoing byte.
    always_ff @(posedge clk) begin
        if (fetch_word) begin
            word_q <= buf_mem[head_word];
        end
        if (issue_byte) begin
            case (head_lane)
                2'd0:    tx_byte <= word_q[7:0];    // lane 0 goes out first.
                2'd1:    tx_byte <= word_q[15:8];
                2'd2:    tx_byte <= word_q[23:16];
                default: tx_byte <= word_q[31:24];
            endcase
        end
    end

    // software must keep the tail from running past the head.
    // nothing here checks for overflow.

endmodule

`default_nettype wire

// File: mmio_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_cfg.svh"

module mmio_decode (
    input  wire uart_mmio_pkg::mmio_req_t req,
    output uart_mmio_pkg::mmio_sel_t      dec
);
    import uart_mmio_pkg::*;

    always_comb begin
        if (req.addr == `UART_HEAD_OFFSET) begin
            dec.sel = SEL_HEAD;
        end else if (req.addr == `UART_TAIL_OFFSET) begin
            dec.sel = SEL_TAIL;
        end else begin
            dec.sel = SEL_BUFFER;
        end
        dec.word_index = req.addr[$clog2(`UART_BUF_WORDS)+1:2];
        dec.wr         = req.start && req.write;
        dec.wdata      = req.wdata;
    end
endmodule

`default_nettype wire

// File: uart_mmio_pkg.sv
`default_nettype none

`include "uart_mmio_cfg.svh"

package uart_mmio_pkg;

    // one command on the processor bus, as driven by the CPU side.
    typedef struct packed {
        logic        start;   // one-cycle command strobe.
        logic        write;   // level, high for a write command.
        logic [31:0] addr;    // byte address.
        logic [31:0] wdata;
    } mmio_req_t;

    // register that an address lands on.
    typedef enum logic [1:0] {
        SEL_BUFFER,
        SEL_HEAD,
        SEL_TAIL
    } reg_sel_e;

    // decoded command handed to the transmit queue.
    typedef struct packed {
        reg_sel_e                           sel;
        logic [$clog2(`UART_BUF_WORDS)-1:0] word_index;
        logic                               wr;     // write already qualified by start.
        logic [31:0]                        wdata;
    } mmio_sel_t;

    typedef enum logic {TXQ_IDLE, TXQ_WAIT_READY} tx_state_e;

    typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_e;

endpackage

`default_nettype wire

// File: uart_mmio_cfg.svh
`ifndef UART_MMIO_CFG_SVH
`define UART_MMIO_CFG_SVH

// clock cycles spent on each serial bit.
// for a real board this would be the clock rate divided by the baud rate.
`define UART_CLKS_PER_BIT 8

// transmit buffer depth in 32-bit words.
// 64 words hold 256 bytes, so the byte pointers below wrap on their own.
`define UART_BUF_WORDS 64

// width of the head and tail byte pointers.
`define UART_PTR_W 8

// byte address of the head pointer register (read only).
`define UART_HEAD_OFFSET 32'h100

// byte address of the tail pointer register.
`define UART_TAIL_OFFSET 32'h104

// any other address falls into the buffer window,
// with the word index taken from address bits 7:2.

`endif
